// ==== hw/rad_pkg.sv ====
package rad_pkg;

	// localbus address and data widths
	parameter int addr_w = 4;
	parameter int data_w = 32;

	// register bank size, last slot is the read-only frame counter
	parameter int n_regs = 16;
	parameter logic [addr_w-1:0] frame_cnt_addr = 4'd15;

	// prefill wait count width, in lb_clk cycles
	parameter int wait_w = 8;

	// host frame sequencer states
	// one prefill cycle, then the programmed wait
	// then one strobe cycle, then the response held until taken
	typedef enum logic [2:0] {
		st_idle,
		st_prefill,
		st_wait,
		st_strobe,
		st_resp
	} seq_state_t;

endpackage

// ==== hw/flag_xdomain.sv ====
`timescale 1ns/1ns

module flag_xdomain (
	input  logic clk1,
	input  logic clk2,
	input  logic arst_n,
	input  logic flagin_clk1,
	output logic flagout_clk2
);

	// toggle in the source domain
	logic toggle_clk1;
	// two synchronizer stages plus one for edge detection
	logic sync1_clk2;
	logic sync2_clk2;
	logic sync3_clk2;

	// each single-cycle input pulse flips the level
	always_ff @(posedge clk1 or negedge arst_n) begin
		if (!arst_n) begin
			toggle_clk1 <= 1'b0;
		end else if (flagin_clk1) begin
			toggle_clk1 <= ~toggle_clk1;
		end
	end

	// the level is stable for many clk1 cycles, safe to sample
	always_ff @(posedge clk2 or negedge arst_n) begin
		if (!arst_n) begin
			sync1_clk2 <= 1'b0;
			sync2_clk2 <= 1'b0;
			sync3_clk2 <= 1'b0;
		end else begin
			sync1_clk2 <= toggle_clk1;
			sync2_clk2 <= sync1_clk2;
			sync3_clk2 <= sync2_clk2;
		end
	end

	// any change of the synchronized level is one pulse in clk2
	assign flagout_clk2 = sync2_clk2 ^ sync3_clk2;

endmodule

// ==== hw/snap_dpram.sv ====
`timescale 1ns/1ns

module snap_dpram #(
	parameter int aw = 4,
	parameter int dw = 32
) (
	// write side
	input  logic          clka,
	input  logic [aw-1:0] addra,
	input  logic          wena,
	input  logic [dw-1:0] dina,
	// read side
	input  logic          clkb,
	input  logic [aw-1:0] addrb,
	output logic [dw-1:0] doutb
);

	// storage, contents undefined until the first fill
	logic [dw-1:0] mem [0:(1<<aw)-1];

	// port a writes only
	always_ff @(posedge clka) begin
		if (wena) begin
			mem[addra] <= dina;
		end
	end

	// port b reads every cycle
	// data shows up one clkb cycle after the address
	always_ff @(posedge clkb) begin
		doutb <= mem[addrb];
	end

endmodule

// ==== hw/app_reg_bank.sv ====
`timescale 1ns/1ns

module app_reg_bank (
	input  logic                       app_clk,
	input  logic                       arst_n,
	// application write port, always ready
	input  logic                       app_wr_valid,
	input  logic [rad_pkg::addr_w-1:0] app_wr_addr,
	input  logic [rad_pkg::data_w-1:0] app_wr_data,
	// readout from the gateway
	input  logic                       xfer_snap,
	input  logic                       xfer_strobe,
	input  logic [rad_pkg::addr_w-1:0] xfer_addr,
	output logic [rad_pkg::data_w-1:0] xfer_odata
);

	import rad_pkg::*;

	// live registers, the top slot is the frame counter instead
	logic [data_w-1:0] live   [0:n_regs-2];
	// frozen copy taken at the snapshot
	logic [data_w-1:0] shadow [0:n_regs-2];
	logic [data_w-1:0] frame_cnt;
	logic [data_w-1:0] mux_data;

	// writes from the application
	// the frame counter slot is read only
	always_ff @(posedge app_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < n_regs - 1; i++) begin
				live[i] <= '0;
			end
		end else if (app_wr_valid && (app_wr_addr != frame_cnt_addr)) begin
			live[app_wr_addr] <= app_wr_data;
		end
	end

	// counts snapshots since reset
	always_ff @(posedge app_clk or negedge arst_n) begin
		if (!arst_n) begin
			frame_cnt <= '0;
		end else if (xfer_snap) begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// shadow captures the live values seen before any write on this edge
	always_ff @(posedge app_clk) begin
		if (xfer_snap) begin
			for (int i = 0; i < n_regs - 1; i++) begin
				shadow[i] <= live[i];
			end
		end
	end

	// during the snap cycle the shadow is not loaded yet
	// so show what it is about to hold
	always_comb begin
		if (xfer_addr == frame_cnt_addr) begin
			mux_data = xfer_snap ? frame_cnt + 1'b1 : frame_cnt;
		end else begin
			mux_data = xfer_snap ? live[xfer_addr] : shadow[xfer_addr];
		end
	end

	// mux only drives the bus when strobed
	assign xfer_odata = xfer_strobe ? mux_data : '0;

endmodule

// ==== hw/jit_rad_gateway.sv ====
`timescale 1ns/1ns

module jit_rad_gateway #(
	parameter bit passthrough = 1'b0
) (
	input  logic                       lb_clk,
	input  logic                       app_clk,
	input  logic                       arst_n,
	// localbus read side
	input  logic [rad_pkg::addr_w-1:0] lb_addr,
	input  logic                       lb_strobe,
	input  logic                       lb_prefill,
	output logic [rad_pkg::data_w-1:0] lb_odata,
	output logic                       lb_error,
	// application mux side
	output logic                       xfer_clk,
	output logic                       xfer_snap,
	output logic                       xfer_strobe,
	output logic [rad_pkg::addr_w-1:0] xfer_addr,
	input  logic [rad_pkg::data_w-1:0] xfer_odata
);

	import rad_pkg::*;

	generate if (passthrough) begin : g_thru
		// no CDC protection, the application mux runs on lb_clk
		logic [data_w-1:0] rd_data;

		assign xfer_clk    = lb_clk;
		assign xfer_snap   = lb_prefill;
		assign xfer_strobe = lb_strobe;
		assign xfer_addr   = lb_addr;
		assign lb_error    = 1'b0;

		// the mux only drives data during the strobe
		// keep the same one-cycle read latency as the RAM
		always_ff @(posedge lb_clk) begin
			if (lb_strobe) begin
				rd_data <= xfer_odata;
			end
		end
		assign lb_odata = rd_data;

	end else begin : g_buffer
		// app_clk side of the gateway and the bank share xfer_clk
		logic              app_prefill;
		logic [addr_w-1:0] addr1;
		logic [addr_w-1:0] addr2;
		logic [data_w-1:0] data2;
		logic              buff_we;
		logic              app_busy;
		logic              busy_meta;
		logic              lb_running;
		logic              lb_pending;

		assign xfer_clk = app_clk;

		// prefill request into the application domain
		flag_xdomain u_trig (
			.clk1         (lb_clk),
			.clk2         (xfer_clk),
			.arst_n       (arst_n),
			.flagin_clk1  (lb_prefill),
			.flagout_clk2 (app_prefill)
		);

		// snapshot is taken on the same cycle as the address 0 strobe
		assign xfer_snap = app_prefill;
		// counter sits at 0 when idle, nonzero while sweeping
		assign xfer_strobe = app_prefill | (|addr1);
		assign xfer_addr   = addr1;

		always_ff @(posedge xfer_clk or negedge arst_n) begin
			if (!arst_n) begin
				addr1    <= '0;
				buff_we  <= 1'b0;
				app_busy <= 1'b0;
			end else begin
				// 16 strobes, then wraps back to 0 and stops
				if (xfer_strobe) begin
					addr1 <= addr1 + 1'b1;
				end
				buff_we  <= xfer_strobe;
				// covers the sweep and the trailing write
				app_busy <= xfer_strobe;
			end
		end

		// address and data delayed one cycle to line up with buff_we
		always_ff @(posedge xfer_clk) begin
			addr2 <= addr1;
			data2 <= xfer_odata;
		end

		snap_dpram #(
			.aw (addr_w),
			.dw (data_w)
		) u_buff (
			.clka  (xfer_clk),
			.addra (addr2),
			.wena  (buff_we),
			.dina  (data2),
			.clkb  (lb_clk),
			.addrb (lb_addr),
			.doutb (lb_odata)
		);

		// busy level back to lb_clk
		// pending covers the gap until the level arrives
		always_ff @(posedge lb_clk or negedge arst_n) begin
			if (!arst_n) begin
				busy_meta  <= 1'b0;
				lb_running <= 1'b0;
				lb_pending <= 1'b0;
			end else begin
				busy_meta  <= app_busy;
				lb_running <= busy_meta;
				if (lb_running) begin
					lb_pending <= 1'b0;
				end else if (lb_prefill) begin
					lb_pending <= 1'b1;
				end
			end
		end

		// any localbus activity while the RAM is being refilled
		assign lb_error = (lb_prefill | lb_strobe) & (lb_pending | lb_running);
	end endgenerate

endmodule

// ==== hw/lb_frame_seq.sv ====
`timescale 1ns/1ns

module lb_frame_seq (
	input  logic                       lb_clk,
	input  logic                       arst_n,
	// host request
	input  logic                       req_valid,
	output logic                       req_ready,
	input  logic [rad_pkg::addr_w-1:0] req_addr,
	input  logic                       req_first,
	// host response
	output logic                       resp_valid,
	input  logic                       resp_ready,
	output logic [rad_pkg::data_w-1:0] resp_data,
	output logic                       resp_err,
	input  logic [rad_pkg::wait_w-1:0] prefill_wait,
	// gateway side
	output logic                       lb_prefill,
	output logic                       lb_strobe,
	output logic [rad_pkg::addr_w-1:0] lb_addr,
	input  logic [rad_pkg::data_w-1:0] lb_odata,
	input  logic                       lb_error
);

	import rad_pkg::*;

	seq_state_t        state;
	logic [wait_w-1:0] wait_cnt;
	logic              req_fire;

	// one request in flight, accepted only when idle
	assign req_ready = (state == st_idle);
	assign req_fire  = req_valid & req_ready;

	assign lb_prefill = (state == st_prefill);
	assign lb_strobe  = (state == st_strobe);

	always_ff @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= st_idle;
			wait_cnt   <= '0;
			resp_valid <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (req_fire) begin
						wait_cnt <= prefill_wait;
						state    <= req_first ? st_prefill : st_strobe;
					end
				end
				st_prefill: begin
					// zero wait goes straight to the strobe
					state <= (wait_cnt == '0) ? st_strobe : st_wait;
				end
				st_wait: begin
					wait_cnt <= wait_cnt - 1'b1;
					if (wait_cnt == 1) begin
						state <= st_strobe;
					end
				end
				st_strobe: begin
					state <= st_resp;
				end
				st_resp: begin
					// first cycle here captures the RAM output
					if (!resp_valid) begin
						resp_valid <= 1'b1;
					end else if (resp_ready) begin
						resp_valid <= 1'b0;
						state      <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// address held for the whole request
	// data and error held under back-pressure
	always_ff @(posedge lb_clk) begin
		if (req_fire) begin
			lb_addr <= req_addr;
		end
		if (state == st_strobe) begin
			resp_err <= lb_error;
		end
		if ((state == st_resp) && !resp_valid) begin
			resp_data <= lb_odata;
		end
	end

endmodule

// ==== hw/rad_top.sv ====
`timescale 1ns/1ns

module rad_top #(
	parameter bit passthrough = 1'b0
) (
	input  logic                       lb_clk,
	input  logic                       app_clk,
	input  logic                       arst_n,
	// host request
	input  logic                       req_valid,
	output logic                       req_ready,
	input  logic [rad_pkg::addr_w-1:0] req_addr,
	input  logic                       req_first,
	// host response
	output logic                       resp_valid,
	input  logic                       resp_ready,
	output logic [rad_pkg::data_w-1:0] resp_data,
	output logic                       resp_err,
	input  logic [rad_pkg::wait_w-1:0] prefill_wait,
	// application writes
	input  logic                       app_wr_valid,
	input  logic [rad_pkg::addr_w-1:0] app_wr_addr,
	input  logic [rad_pkg::data_w-1:0] app_wr_data
);

	import rad_pkg::*;

	// localbus between sequencer and gateway
	logic              lb_prefill;
	logic              lb_strobe;
	logic [addr_w-1:0] lb_addr;
	logic [data_w-1:0] lb_odata;
	logic              lb_error;
	// gateway to register bank
	logic              xfer_clk;
	logic              xfer_snap;
	logic              xfer_strobe;
	logic [addr_w-1:0] xfer_addr;
	logic [data_w-1:0] xfer_odata;

	lb_frame_seq u_seq (
		.lb_clk       (lb_clk),
		.arst_n       (arst_n),
		.req_valid    (req_valid),
		.req_ready    (req_ready),
		.req_addr     (req_addr),
		.req_first    (req_first),
		.resp_valid   (resp_valid),
		.resp_ready   (resp_ready),
		.resp_data    (resp_data),
		.resp_err     (resp_err),
		.prefill_wait (prefill_wait),
		.lb_prefill   (lb_prefill),
		.lb_strobe    (lb_strobe),
		.lb_addr      (lb_addr),
		.lb_odata     (lb_odata),
		.lb_error     (lb_error)
	);

	jit_rad_gateway #(
		.passthrough (passthrough)
	) u_gate (
		.lb_clk      (lb_clk),
		.app_clk     (app_clk),
		.arst_n      (arst_n),
		.lb_addr     (lb_addr),
		.lb_strobe   (lb_strobe),
		.lb_prefill  (lb_prefill),
		.lb_odata    (lb_odata),
		.lb_error    (lb_error),
		.xfer_clk    (xfer_clk),
		.xfer_snap   (xfer_snap),
		.xfer_strobe (xfer_strobe),
		.xfer_addr   (xfer_addr),
		.xfer_odata  (xfer_odata)
	);

	// bank runs on whatever clock the gateway hands it
	// app_clk when buffered
	app_reg_bank u_bank (
		.app_clk      (xfer_clk),
		.arst_n       (arst_n),
		.app_wr_valid (app_wr_valid),
		.app_wr_addr  (app_wr_addr),
		.app_wr_data  (app_wr_data),
		.xfer_snap    (xfer_snap),
		.xfer_strobe  (xfer_strobe),
		.xfer_addr    (xfer_addr),
		.xfer_odata   (xfer_odata)
	);

endmodule

// ==== test/rad_tb.sv ====
`timescale 1ns/1ns

module rad_tb;

	import rad_pkg::*;

	localparam int lb_period  = 100;
	localparam int app_period = 70;
	// longest request is a 255-cycle wait plus a few
	localparam int resp_limit = 300;

	logic              lb_clk;
	logic              app_clk;
	logic              arst_n;
	// host side
	logic              req_valid;
	logic              req_ready;
	logic [addr_w-1:0] req_addr;
	logic              req_first;
	logic              resp_valid;
	logic              resp_ready;
	logic [data_w-1:0] resp_data;
	logic              resp_err;
	logic [wait_w-1:0] prefill_wait;
	// application side
	logic              app_wr_valid;
	logic [addr_w-1:0] app_wr_addr;
	logic [data_w-1:0] app_wr_data;

	// file data is xored with one lcg word per address
	logic [data_w-1:0] mask [0:n_regs-1];
	logic [31:0]       lcg_state;
	int                err_count;
	int                check_count;
	// cycles of resp_ready low on the next read
	int                hold_cycles;
	bit                aborted;

	always #(lb_period / 2) lb_clk = ~lb_clk;
	always #(app_period / 2) app_clk = ~app_clk;

	rad_top #(
		.passthrough (1'b0)
	) DUT (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic compare_data(input string name, input logic [data_w-1:0] exp,
		input logic [data_w-1:0] act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic compare_err(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	// a short stimulus line stops the run
	task automatic flag_bad_line();
		err_count++;
		aborted = 1'b1;
		$display("stimulus line has missing fields");
	endtask

	task automatic finish_run();
		$display("checks %0d errors %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	// one write cycle, the bank is always ready
	task automatic app_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
		@(posedge app_clk);
		#5;
		app_wr_valid = 1'b1;
		app_wr_addr  = addr;
		app_wr_data  = data;
		@(posedge app_clk);
		#5;
		app_wr_valid = 1'b0;
	endtask

	task automatic host_read(input logic [addr_w-1:0] addr, input logic first,
		input logic [wait_w-1:0] wait_len, input logic [data_w-1:0] exp_data,
		input logic exp_err);
		int cycles;
		@(posedge lb_clk);
		#5;
		cycles       = 0;
		req_valid    = 1'b1;
		req_addr     = addr;
		req_first    = first;
		prefill_wait = wait_len;
		resp_ready   = (hold_cycles == 0);
		// sequencer idle here, so the request goes on the next edge
		compare_err("req_ready", 1'b1, req_ready);
		@(posedge lb_clk);
		#5;
		req_valid = 1'b0;
		while (!resp_valid && cycles < resp_limit) begin
			@(posedge lb_clk);
			#5;
			cycles++;
		end
		if (!resp_valid) begin
			err_count++;
			aborted = 1'b1;
			$display("no response to the read of address %h", addr);
		end else begin
			// a second request queues behind the held response
			req_valid = (hold_cycles != 0);
			repeat (hold_cycles) begin
				@(posedge lb_clk);
				#5;
				compare_data("resp_data", exp_data, resp_data);
				compare_err("resp_valid", 1'b1, resp_valid);
				compare_err("req_ready", 1'b0, req_ready);
			end
			req_valid   = 1'b0;
			hold_cycles = 0;
			resp_ready  = 1'b1;
			compare_data("resp_data", exp_data, resp_data);
			compare_err("resp_err", exp_err, resp_err);
			@(posedge lb_clk);
			#5;
			compare_err("resp_valid", 1'b0, resp_valid);
		end
	endtask

	initial begin
		int                fd;
		int                code;
		logic [63:0]       cmd;
		logic [1023:0]     line;
		logic [addr_w-1:0] a;
		logic              f;
		logic [wait_w-1:0] w;
		logic [data_w-1:0] d;
		logic              e;
		lb_clk       = 1'b0;
		app_clk      = 1'b0;
		arst_n       = 1'b0;
		req_valid    = 1'b0;
		req_addr     = '0;
		req_first    = 1'b0;
		resp_ready   = 1'b1;
		prefill_wait = '0;
		app_wr_valid = 1'b0;
		app_wr_addr  = '0;
		app_wr_data  = '0;
		err_count    = 0;
		check_count  = 0;
		hold_cycles  = 0;
		aborted      = 1'b0;
		// counter slot keeps plain counts
		lcg_state = 32'hee24;
		for (int i = 0; i < n_regs; i++) begin
			lcg_state = lcg_next(lcg_state);
			mask[i]   = (i == frame_cnt_addr) ? '0 : lcg_state;
		end
		repeat (10) @(posedge lb_clk);
		#5;
		arst_n = 1'b1;
		fd = $fopen("test/rad_stim.txt", "r");
		if (fd == 0) begin
			err_count++;
			$display("cannot open the stimulus file test/rad_stim.txt");
		end else begin
			while (!aborted && $fscanf(fd, "%s", cmd) == 1) begin
				if (cmd == "w") begin
					code = $fscanf(fd, "%h %h", a, d);
					if (code == 2) begin
						app_write(a, d ^ mask[a]);
					end else begin
						flag_bad_line();
					end
				end else if (cmd == "r") begin
					code = $fscanf(fd, "%h %d %d %h %d", a, f, w, d, e);
					if (code == 5) begin
						host_read(a, f, w, d ^ mask[a], e);
					end else begin
						flag_bad_line();
					end
				end else if (cmd == "p") begin
					code = $fscanf(fd, "%d", w);
					if (code == 1) begin
						hold_cycles = w;
					end else begin
						flag_bad_line();
					end
				end else begin
					// comment, skip to end of line
					code = $fgets(line, fd);
				end
			end
			$fclose(fd);
		end
		finish_run();
	end

	// limit scales with the stimulus length
	initial begin
		int            fd;
		int            n_lines;
		logic [1023:0] line;
		n_lines = 0;
		fd = $fopen("test/rad_stim.txt", "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				n_lines++;
			end
			$fclose(fd);
		end
		#((n_lines + 1) * 100 * lb_period);
		err_count++;
		$display("watchdog expired before the stimulus finished");
		finish_run();
	end

endmodule

// ==== src.f ====
hw/rad_pkg.sv
hw/flag_xdomain.sv
hw/snap_dpram.sv
hw/app_reg_bank.sv
hw/jit_rad_gateway.sv
hw/lb_frame_seq.sv
hw/rad_top.sv
test/rad_tb.sv

// ==== test/rad_stim.txt ====
# w addr data | r addr first wait exp_data exp_err | p cycles with resp_ready low
# addr and data in hex, wait in decimal, data xored with a per-address lcg word
w 0 00000100
w 1 00000101
w 2 00000102
w 3 00000103
w 4 00000104
w 5 00000105
w 6 00000106
w 7 00000107
w 8 00000108
w 9 00000109
w a 0000010a
w b 0000010b
w c 0000010c
w d 0000010d
w e 0000010e
r 0 1 40 00000100 0
r 9 0 0 00000109 0
r e 0 0 0000010e 0
r f 0 0 00000001 0
w 7 00000777
r 7 0 0 00000107 0
w e 00000eee
r e 0 0 0000010e 0
r 7 1 40 00000777 0
r e 0 0 00000eee 0
r f 0 0 00000002 0
r 5 1 0 00000105 1
r f 1 40 00000004 0
p 5
r e 0 0 00000eee 0
